// ==== design/debug_pkg.sv ====
`default_nettype none

package debug_pkg;

    //////////////////////////////
    // Bus and word widths.
    //////////////////////////////

    localparam int unsigned DATA_WIDTH     = 32; // APB data and snapshot word.
    localparam int unsigned APB_ADDR_WIDTH = 4;
    localparam int unsigned CMD_WIDTH      = 4;

    //////////////////////////////
    // APB register map.
    //////////////////////////////

    localparam logic [APB_ADDR_WIDTH-1:0] REG_CTRL   = 4'h0; // Run, step, clear.
    localparam logic [APB_ADDR_WIDTH-1:0] REG_CMD    = 4'h4; // Database command.
    localparam logic [APB_ADDR_WIDTH-1:0] REG_DATA   = 4'h8; // Snapshot word.
    localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS = 4'hC; // Halted and run.

    // Bit positions inside CTRL and STATUS.
    localparam int unsigned CTRL_RUN_BIT      = 0;
    localparam int unsigned CTRL_STEP_BIT     = 1;
    localparam int unsigned CTRL_CLEAR_BIT    = 2;
    localparam int unsigned STATUS_HALTED_BIT = 0;
    localparam int unsigned STATUS_RUN_BIT    = 1;

    //////////////////////////////
    // Snapshot commands.
    //////////////////////////////

    localparam logic [CMD_WIDTH-1:0] CMD_CAPTURE      = 4'd1;  // Copy all stage values.
    localparam logic [CMD_WIDTH-1:0] CMD_PC_CYCLES    = 4'd2;
    localparam logic [CMD_WIDTH-1:0] CMD_ADDER_BRANCH = 4'd3;
    localparam logic [CMD_WIDTH-1:0] CMD_INSTRUCTION  = 4'd4;
    localparam logic [CMD_WIDTH-1:0] CMD_IMMEDIATE    = 4'd5;
    localparam logic [CMD_WIDTH-1:0] CMD_DECODE       = 4'd6;
    localparam logic [CMD_WIDTH-1:0] CMD_CLEAR        = 4'd15; // Zero the held values.

endpackage

`default_nettype wire

// ==== design/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    //////////////////////////////
    // Front end widths.
    //////////////////////////////

    localparam int unsigned PC_WIDTH        = 11; // Byte address.
    localparam int unsigned REG_INDEX_WIDTH = 5;
    localparam int unsigned CYCLE_WIDTH     = 16;
    localparam int unsigned INSTR_WIDTH     = 32;
    localparam int unsigned OPCODE_WIDTH    = 6;

    // Opcodes the stage acts on.
    localparam logic [OPCODE_WIDTH-1:0] OPCODE_BRANCH = 6'b000100; // Always taken.
    localparam logic [OPCODE_WIDTH-1:0] OPCODE_HALT   = 6'b111111;

    //////////////////////////////
    // Program ROM.
    //////////////////////////////

    localparam int unsigned ROM_DEPTH       = 16;
    localparam int unsigned ROM_INDEX_WIDTH = $clog2(ROM_DEPTH);

    localparam logic [INSTR_WIDTH-1:0] PROGRAM_ROM [ROM_DEPTH] = '{
        32'h0022_1821, // 0: addu $3, $1, $2.
        32'h2004_0005, // 1: addi $4, $0, 5.
        32'h2085_FFFD, // 2: addi $5, $4, -3.
        32'h00A4_3022, // 3: sub  $6, $5, $4.
        32'h1000_0002, // 4: beq  $0, $0, +2 to word 7.
        32'h0064_3825, // 5: or   $7, $3, $4 (skipped).
        32'h0022_502A, // 6: slt  $10, $1, $2 (skipped).
        32'h00C5_4024, // 7: and  $8, $6, $5.
        32'h3509_00FF, // 8: ori  $9, $8, 0xff.
        32'hFC00_0000, // 9: halt.
        32'h0000_0000,
        32'h0000_0000,
        32'h0000_0000,
        32'h0000_0000,
        32'h0000_0000,
        32'h0000_0000
    };

endpackage

`default_nettype wire

// ==== design/fetch_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_decode_stage (
    input  logic                                   i_clock,
    input  logic                                   i_soft_reset,
    input  logic                                   i_run,
    input  logic                                   i_step,
    input  logic                                   i_clear,

    output logic [pipe_pkg::PC_WIDTH-1:0]          o_pc,
    output logic [pipe_pkg::PC_WIDTH-1:0]          o_adder_pc,
    output logic [pipe_pkg::PC_WIDTH-1:0]          o_branch_dir,
    output logic [pipe_pkg::CYCLE_WIDTH-1:0]       o_cycle_count,
    output logic [pipe_pkg::INSTR_WIDTH-1:0]       o_instruction,

    output logic [pipe_pkg::REG_INDEX_WIDTH-1:0]   o_rs,
    output logic [pipe_pkg::REG_INDEX_WIDTH-1:0]   o_rt,
    output logic [pipe_pkg::REG_INDEX_WIDTH-1:0]   o_rd,
    output logic [pipe_pkg::INSTR_WIDTH-1:0]       o_immediate,
    output logic                                   o_branch_taken,
    output logic                                   o_halted
);

    import pipe_pkg::*;

    localparam int unsigned IMM_WIDTH = 16;

    logic [PC_WIDTH-1:0]        pc_q;
    logic [CYCLE_WIDTH-1:0]     cycle_q;
    logic                       halted_q;

    logic [ROM_INDEX_WIDTH-1:0] rom_index;
    logic [INSTR_WIDTH-1:0]     instruction;
    logic [OPCODE_WIDTH-1:0]    opcode;
    logic [INSTR_WIDTH-1:0]     immediate;
    logic [PC_WIDTH-1:0]        adder_pc;
    logic [PC_WIDTH-1:0]        branch_dir;
    logic                       branch_taken;
    logic                       is_halt;
    logic                       advance;

    //////////////////////////////
    // Fetch and decode.
    //////////////////////////////

    assign rom_index   = pc_q[ROM_INDEX_WIDTH+1:2]; // Word index with the byte bits dropped.
    assign instruction = PROGRAM_ROM[rom_index];
    assign opcode      = instruction[INSTR_WIDTH-1 -: OPCODE_WIDTH];

    // Sign extended 16-bit immediate.
    assign immediate = {{(INSTR_WIDTH-IMM_WIDTH){instruction[IMM_WIDTH-1]}},
                        instruction[IMM_WIDTH-1:0]};

    assign adder_pc     = pc_q + PC_WIDTH'(4);
    assign branch_dir   = adder_pc + {immediate[PC_WIDTH-3:0], 2'b00}; // Word offset.
    assign branch_taken = (opcode == OPCODE_BRANCH);
    assign is_halt      = (opcode == OPCODE_HALT);

    assign advance = (i_run | i_step) & ~halted_q;

    //////////////////////////////
    // PC, cycle count and halt.
    //////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset || i_clear) begin
            pc_q     <= '0;
            cycle_q  <= '0;
            halted_q <= 1'b0;
        end else if (advance) begin
            cycle_q <= cycle_q + CYCLE_WIDTH'(1);
            if (is_halt) begin
                halted_q <= 1'b1; // PC stays on the halt word.
            end else if (branch_taken) begin
                pc_q <= branch_dir;
            end else begin
                pc_q <= adder_pc;
            end
        end
    end

    assign o_pc           = pc_q;
    assign o_adder_pc     = adder_pc;
    assign o_branch_dir   = branch_dir;
    assign o_cycle_count  = cycle_q;
    assign o_instruction  = instruction;
    assign o_rs           = instruction[25:21];
    assign o_rt           = instruction[20:16];
    assign o_rd           = instruction[15:11];
    assign o_immediate    = immediate;
    assign o_branch_taken = branch_taken;
    assign o_halted       = halted_q;

endmodule

`default_nettype wire

// ==== design/snapshot_database.sv ====
`timescale 1ns/1ps
`default_nettype none

module snapshot_database (
    input  logic                                  i_clock,
    input  logic                                  i_soft_reset,
    input  logic [debug_pkg::CMD_WIDTH-1:0]       i_command,
    input  logic                                  i_command_valid,

    // Stage values.
    input  logic [pipe_pkg::PC_WIDTH-1:0]         i_pc,
    input  logic [pipe_pkg::PC_WIDTH-1:0]         i_adder_pc,
    input  logic [pipe_pkg::PC_WIDTH-1:0]         i_branch_dir,
    input  logic [pipe_pkg::CYCLE_WIDTH-1:0]      i_cycle_count,
    input  logic [pipe_pkg::INSTR_WIDTH-1:0]      i_instruction,
    input  logic [pipe_pkg::REG_INDEX_WIDTH-1:0]  i_rs,
    input  logic [pipe_pkg::REG_INDEX_WIDTH-1:0]  i_rt,
    input  logic [pipe_pkg::REG_INDEX_WIDTH-1:0]  i_rd,
    input  logic [pipe_pkg::INSTR_WIDTH-1:0]      i_immediate,
    input  logic                                  i_branch_taken,
    input  logic                                  i_halted,

    output logic [debug_pkg::DATA_WIDTH-1:0]      o_snapshot_word
);

    import debug_pkg::*;
    import pipe_pkg::*;

    localparam int unsigned HALF_WIDTH = DATA_WIDTH / 2;

    logic [PC_WIDTH-1:0]        held_pc;
    logic [PC_WIDTH-1:0]        held_adder_pc;
    logic [PC_WIDTH-1:0]        held_branch_dir;
    logic [CYCLE_WIDTH-1:0]     held_cycle_count;
    logic [INSTR_WIDTH-1:0]     held_instruction;
    logic [REG_INDEX_WIDTH-1:0] held_rs;
    logic [REG_INDEX_WIDTH-1:0] held_rt;
    logic [REG_INDEX_WIDTH-1:0] held_rd;
    logic [INSTR_WIDTH-1:0]     held_immediate;
    logic                       held_branch_taken;
    logic                       held_halted;

    logic [DATA_WIDTH-1:0]      pc_cycles_word;
    logic [DATA_WIDTH-1:0]      adder_branch_word;
    logic [DATA_WIDTH-1:0]      decode_word;
    logic                       clear_cmd;
    logic                       capture_cmd;

    assign clear_cmd   = i_command_valid && (i_command == CMD_CLEAR);
    assign capture_cmd = i_command_valid && (i_command == CMD_CAPTURE);

    //////////////////////////////
    // Holding registers.
    //////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset || clear_cmd) begin
            held_pc           <= '0;
            held_adder_pc     <= '0;
            held_branch_dir   <= '0;
            held_cycle_count  <= '0;
            held_instruction  <= '0;
            held_rs           <= '0;
            held_rt           <= '0;
            held_rd           <= '0;
            held_immediate    <= '0;
            held_branch_taken <= 1'b0;
            held_halted       <= 1'b0;
        end else if (capture_cmd) begin
            held_pc           <= i_pc;
            held_adder_pc     <= i_adder_pc;
            held_branch_dir   <= i_branch_dir;
            held_cycle_count  <= i_cycle_count;
            held_instruction  <= i_instruction;
            held_rs           <= i_rs;
            held_rt           <= i_rt;
            held_rd           <= i_rd;
            held_immediate    <= i_immediate;
            held_branch_taken <= i_branch_taken;
            held_halted       <= i_halted;
        end
    end

    // Readout layouts.
    assign pc_cycles_word = {{(HALF_WIDTH-PC_WIDTH){1'b0}}, held_pc, held_cycle_count};

    assign adder_branch_word = {{(HALF_WIDTH-PC_WIDTH){1'b0}}, held_adder_pc,
                                {(HALF_WIDTH-PC_WIDTH-1){1'b0}}, held_branch_taken,
                                held_branch_dir};

    assign decode_word = {held_instruction[INSTR_WIDTH-1 -: OPCODE_WIDTH], held_halted,
                          {(DATA_WIDTH-OPCODE_WIDTH-1-3*REG_INDEX_WIDTH){1'b0}},
                          held_rs, held_rt, held_rd};

    //////////////////////////////
    // Readout word.
    //////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            o_snapshot_word <= '0;
        end else if (i_command_valid) begin
            case (i_command)
                CMD_CAPTURE:      o_snapshot_word <= '0; // A fresh capture selects nothing.
                CMD_PC_CYCLES:    o_snapshot_word <= pc_cycles_word;
                CMD_ADDER_BRANCH: o_snapshot_word <= adder_branch_word;
                CMD_INSTRUCTION:  o_snapshot_word <= held_instruction;
                CMD_IMMEDIATE:    o_snapshot_word <= held_immediate;
                CMD_DECODE:       o_snapshot_word <= decode_word;
                default:          o_snapshot_word <= o_snapshot_word;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/debug_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module debug_regs (
    input  logic                                    i_clock,
    input  logic                                    i_soft_reset,
    input  logic                                    i_psel,
    input  logic                                    i_penable,
    input  logic                                    i_pwrite,
    input  logic [debug_pkg::APB_ADDR_WIDTH-1:0]    i_paddr,
    input  logic [debug_pkg::DATA_WIDTH-1:0]        i_pwdata,

    input  logic                                    i_halted,
    input  logic [debug_pkg::DATA_WIDTH-1:0]        i_snapshot_word,

    output logic [debug_pkg::DATA_WIDTH-1:0]        o_prdata,
    output logic                                    o_run,
    output logic                                    o_step,
    output logic                                    o_clear,
    output logic [debug_pkg::CMD_WIDTH-1:0]         o_command,
    output logic                                    o_command_valid
);

    import debug_pkg::*;

    logic write_access;
    logic read_access;
    logic ctrl_write;
    logic cmd_write;

    //////////////////////////////
    // APB decode.
    //////////////////////////////

    // Writes land at the access edge while reads cover setup and access.
    assign write_access = i_psel & i_penable & i_pwrite;
    assign read_access  = i_psel & ~i_pwrite;

    assign ctrl_write = write_access && (i_paddr == REG_CTRL);
    assign cmd_write  = write_access && (i_paddr == REG_CMD);

    //////////////////////////////
    // Control bits and pulses.
    //////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            o_run   <= 1'b0;
            o_step  <= 1'b0;
            o_clear <= 1'b0;
        end else begin
            if (ctrl_write) begin
                o_run <= i_pwdata[CTRL_RUN_BIT]; // Held until rewritten.
            end
            o_step  <= ctrl_write & i_pwdata[CTRL_STEP_BIT];  // One cycle.
            o_clear <= ctrl_write & i_pwdata[CTRL_CLEAR_BIT]; // One cycle.
        end
    end

    always_ff @(posedge i_clock) begin
        if (!i_soft_reset) begin
            o_command       <= '0;
            o_command_valid <= 1'b0;
        end else begin
            o_command_valid <= cmd_write;
            if (cmd_write) begin
                o_command <= i_pwdata[CMD_WIDTH-1:0];
            end
        end
    end

    //////////////////////////////
    // Readback.
    //////////////////////////////

    always_comb begin
        o_prdata = '0;
        if (read_access) begin
            case (i_paddr)
                REG_CTRL: begin
                    o_prdata[CTRL_RUN_BIT] = o_run; // Step and clear read as 0.
                end
                REG_CMD: begin
                    o_prdata[CMD_WIDTH-1:0] = o_command; // Last command sent.
                end
                REG_DATA: begin
                    o_prdata = i_snapshot_word;
                end
                REG_STATUS: begin
                    o_prdata[STATUS_HALTED_BIT] = i_halted;
                    o_prdata[STATUS_RUN_BIT]    = o_run;
                end
                default: begin
                    o_prdata = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/debug_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module debug_top (
    input  logic                                  i_clock,
    input  logic                                  i_soft_reset,
    input  logic                                  i_psel,
    input  logic                                  i_penable,
    input  logic                                  i_pwrite,
    input  logic [debug_pkg::APB_ADDR_WIDTH-1:0]  i_paddr,
    input  logic [debug_pkg::DATA_WIDTH-1:0]      i_pwdata,
    output logic [debug_pkg::DATA_WIDTH-1:0]      o_prdata
);

    import debug_pkg::*;
    import pipe_pkg::*;

    // Register block to stage and database.
    logic                       run;
    logic                       step;
    logic                       clear;
    logic [CMD_WIDTH-1:0]       command;
    logic                       command_valid;
    logic [DATA_WIDTH-1:0]      snapshot_word;

    // Stage values.
    logic [PC_WIDTH-1:0]        pc;
    logic [PC_WIDTH-1:0]        adder_pc;
    logic [PC_WIDTH-1:0]        branch_dir;
    logic [CYCLE_WIDTH-1:0]     cycle_count;
    logic [INSTR_WIDTH-1:0]     instruction;
    logic [REG_INDEX_WIDTH-1:0] rs;
    logic [REG_INDEX_WIDTH-1:0] rt;
    logic [REG_INDEX_WIDTH-1:0] rd;
    logic [INSTR_WIDTH-1:0]     immediate;
    logic                       branch_taken;
    logic                       halted;

    debug_regs u_debug_regs (
        .i_clock         (i_clock),
        .i_soft_reset    (i_soft_reset),
        .i_psel          (i_psel),
        .i_penable       (i_penable),
        .i_pwrite        (i_pwrite),
        .i_paddr         (i_paddr),
        .i_pwdata        (i_pwdata),
        .i_halted        (halted),
        .i_snapshot_word (snapshot_word),
        .o_prdata        (o_prdata),
        .o_run           (run),
        .o_step          (step),
        .o_clear         (clear),
        .o_command       (command),
        .o_command_valid (command_valid)
    );

    fetch_decode_stage u_fetch_decode_stage (
        .i_clock        (i_clock),
        .i_soft_reset   (i_soft_reset),
        .i_run          (run),
        .i_step         (step),
        .i_clear        (clear),
        .o_pc           (pc),
        .o_adder_pc     (adder_pc),
        .o_branch_dir   (branch_dir),
        .o_cycle_count  (cycle_count),
        .o_instruction  (instruction),
        .o_rs           (rs),
        .o_rt           (rt),
        .o_rd           (rd),
        .o_immediate    (immediate),
        .o_branch_taken (branch_taken),
        .o_halted       (halted)
    );

    snapshot_database u_snapshot_database (
        .i_clock         (i_clock),
        .i_soft_reset    (i_soft_reset),
        .i_command       (command),
        .i_command_valid (command_valid),
        .i_pc            (pc),
        .i_adder_pc      (adder_pc),
        .i_branch_dir    (branch_dir),
        .i_cycle_count   (cycle_count),
        .i_instruction   (instruction),
        .i_rs            (rs),
        .i_rt            (rt),
        .i_rd            (rd),
        .i_immediate     (immediate),
        .i_branch_taken  (branch_taken),
        .i_halted        (halted),
        .o_snapshot_word (snapshot_word)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic o_clock,
    output logic o_soft_reset
);

    localparam int unsigned HALF_PERIOD  = 2; // 4 ns clock.
    localparam int unsigned RESET_CYCLES = 4;

    initial begin
        o_clock = 1'b0;
        forever #(HALF_PERIOD) o_clock = ~o_clock;
    end

    // Reset is held low for the first few rising edges.
    initial begin
        o_soft_reset <= 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clock);
        o_soft_reset <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tests/tb_debug_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_debug_top;

    import debug_pkg::*;
    import pipe_pkg::*;

    localparam int unsigned WAIT_LIMIT = 200; // Cycles before a wait gives up.

    logic                      clock;
    logic                      soft_reset;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [APB_ADDR_WIDTH-1:0] paddr;
    logic [DATA_WIDTH-1:0]     pwdata;
    logic [DATA_WIDTH-1:0]     prdata;

    // Reference model of the stage and of the held snapshot.
    logic [PC_WIDTH-1:0]    model_pc;
    logic [CYCLE_WIDTH-1:0] model_count;
    logic                   model_halted;
    logic [PC_WIDTH-1:0]    held_pc;
    logic [CYCLE_WIDTH-1:0] held_count;
    logic                   held_halted;
    logic                   held_zero;   // Holding registers are all zero.

    logic [31:0] rng_state;
    int unsigned error_count;
    int unsigned test_count;
    int unsigned errors_at_start;

    tb_clock u_tb_clock (
        .o_clock      (clock),
        .o_soft_reset (soft_reset)
    );

    debug_top u_debug_top (
        .i_clock      (clock),
        .i_soft_reset (soft_reset),
        .i_psel       (psel),
        .i_penable    (penable),
        .i_pwrite     (pwrite),
        .i_paddr      (paddr),
        .i_pwdata     (pwdata),
        .o_prdata     (prdata)
    );

    //////////////////////////////
    // Reference model.
    //////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [INSTR_WIDTH-1:0] rom_word(input logic [PC_WIDTH-1:0] pc);
        return PROGRAM_ROM[pc[ROM_INDEX_WIDTH+1:2]]; // Byte address to word index.
    endfunction

    function automatic logic [INSTR_WIDTH-1:0] sign_extend(input logic [INSTR_WIDTH-1:0] instr);
        return {{16{instr[15]}}, instr[15:0]};
    endfunction

    // Taken target is PC plus 4 plus the immediate in words.
    function automatic logic [PC_WIDTH-1:0] branch_target(input logic [PC_WIDTH-1:0] pc,
                                                          input logic [INSTR_WIDTH-1:0] instr);
        logic [INSTR_WIDTH-1:0] offset;
        offset = sign_extend(instr) << 2;
        return pc + PC_WIDTH'(4) + offset[PC_WIDTH-1:0];
    endfunction

    function automatic logic [DATA_WIDTH-1:0] expected_word(input logic [CMD_WIDTH-1:0] cmd);
        logic [INSTR_WIDTH-1:0] instr;
        logic [DATA_WIDTH-1:0]  word;
        instr = rom_word(held_pc);
        word  = '0;
        if (!held_zero) begin
            case (cmd)
                CMD_PC_CYCLES: begin
                    word[26:16] = held_pc;
                    word[15:0]  = held_count;
                end
                CMD_ADDER_BRANCH: begin
                    word[26:16] = held_pc + PC_WIDTH'(4);
                    word[11]    = (instr[31:26] == OPCODE_BRANCH);
                    word[10:0]  = branch_target(held_pc, instr);
                end
                CMD_INSTRUCTION: word = instr;
                CMD_IMMEDIATE:   word = sign_extend(instr);
                CMD_DECODE: begin
                    word[31:26] = instr[31:26];
                    word[25]    = held_halted;
                    word[14:0]  = instr[25:11]; // rs, rt, rd.
                end
                default: word = '0;
            endcase
        end
        return word;
    endfunction

    task automatic model_reset();
        model_pc     = '0;
        model_count  = '0;
        model_halted = 1'b0;
    endtask

    task automatic model_advance();
        logic [INSTR_WIDTH-1:0] instr;
        instr = rom_word(model_pc);
        if (!model_halted) begin
            model_count = model_count + CYCLE_WIDTH'(1);
            if (instr[31:26] == OPCODE_HALT) begin
                model_halted = 1'b1; // PC stays on the halt word.
            end else if (instr[31:26] == OPCODE_BRANCH) begin
                model_pc = branch_target(model_pc, instr);
            end else begin
                model_pc = model_pc + PC_WIDTH'(4);
            end
        end
    endtask

    //////////////////////////////
    // Reporting.
    //////////////////////////////

    task automatic finish_run();
        $display("tests run %0d, errors %0d", test_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    task automatic timeout_abort(input string reason);
        $display("ERROR: timeout, %s", reason);
        error_count++;
        finish_run();
    endtask

    task automatic compare_word(input string name, input logic [DATA_WIDTH-1:0] expected,
                                input logic [DATA_WIDTH-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_status(input string name, input logic exp_halted,
                                  input logic exp_run, input logic [DATA_WIDTH-1:0] actual);
        logic [DATA_WIDTH-1:0] expected;
        expected                    = '0;
        expected[STATUS_HALTED_BIT] = exp_halted;
        expected[STATUS_RUN_BIT]    = exp_run;
        if (actual !== expected) begin
            $display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic start_test();
        test_count++;
        errors_at_start = error_count;
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, error_count - errors_at_start);
    endtask

    //////////////////////////////
    // APB access.
    //////////////////////////////

    task automatic wait_reset_release();
        int unsigned cycles;
        cycles = 0;
        while (soft_reset !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(posedge clock);
            cycles++;
        end
        if (soft_reset !== 1'b1) begin
            timeout_abort("reset was never released");
        end
    endtask

    task automatic apb_write(input logic [APB_ADDR_WIDTH-1:0] addr,
                             input logic [DATA_WIDTH-1:0] data);
        wait_reset_release();
        @(posedge clock);
        psel    <= 1'b1; // Setup phase.
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clock);
        penable <= 1'b1;
        @(posedge clock); // The write lands on this access edge.
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [APB_ADDR_WIDTH-1:0] addr,
                            output logic [DATA_WIDTH-1:0] data);
        wait_reset_release();
        @(posedge clock);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clock);
        penable <= 1'b1;
        @(negedge clock);
        data = prdata; // Mid access phase.
        @(posedge clock);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic step_once();
        apb_write(REG_CTRL, DATA_WIDTH'(1) << CTRL_STEP_BIT);
        model_advance();
    endtask

    task automatic capture_snapshot();
        apb_write(REG_CMD, DATA_WIDTH'(CMD_CAPTURE));
        held_pc     = model_pc;
        held_count  = model_count;
        held_halted = model_halted;
        held_zero   = 1'b0;
    endtask

    task automatic check_selection(input string name, input logic [CMD_WIDTH-1:0] cmd);
        logic [DATA_WIDTH-1:0] data;
        apb_write(REG_CMD, DATA_WIDTH'(cmd));
        apb_read(REG_DATA, data);
        compare_word(name, expected_word(cmd), data);
    endtask

    //////////////////////////////
    // Directed tests.
    //////////////////////////////

    task automatic test_reset_state();
        logic [DATA_WIDTH-1:0] data;
        start_test();
        apb_read(REG_STATUS, data);
        compare_status("reset status", 1'b0, 1'b0, data);
        apb_read(REG_DATA, data);
        compare_word("reset data", '0, data);
        capture_snapshot();
        check_selection("reset pc_cycles", CMD_PC_CYCLES);
        end_test("reset_state");
    endtask

    task automatic test_random_steps();
        int unsigned steps;
        start_test();
        rng_state = xorshift32(rng_state);
        steps     = 32'(rng_state % 32'd4) + 1; // Stays short of the halt word.
        repeat (steps) step_once();
        capture_snapshot();
        check_selection("random_steps pc_cycles", CMD_PC_CYCLES);
        check_selection("random_steps instruction", CMD_INSTRUCTION);
        check_selection("random_steps decode", CMD_DECODE);
        end_test("random_steps");
    endtask

    task automatic test_branch();
        logic [INSTR_WIDTH-1:0] instr;
        logic [DATA_WIDTH-1:0]  data;
        int unsigned            guard;
        start_test();
        guard = 0;
        instr = rom_word(model_pc);
        while (instr[31:26] != OPCODE_BRANCH && guard < ROM_DEPTH) begin
            step_once();
            instr = rom_word(model_pc);
            guard++;
        end
        if (instr[31:26] != OPCODE_BRANCH) begin
            $display("ERROR: branch test never reached a branch word");
            error_count++;
        end
        capture_snapshot();
        apb_read(REG_DATA, data); // A capture leaves the readout word at zero.
        compare_word("branch capture data", '0, data);
        check_selection("branch adder_branch", CMD_ADDER_BRANCH);
        step_once();
        capture_snapshot();
        check_selection("branch target pc", CMD_PC_CYCLES);
        end_test("branch");
    endtask

    task automatic test_negative_immediate();
        logic [INSTR_WIDTH-1:0] instr;
        int unsigned            guard;
        start_test();
        apb_write(REG_CTRL, DATA_WIDTH'(1) << CTRL_CLEAR_BIT);
        model_reset();
        guard = 0;
        instr = rom_word(model_pc);
        while ((!instr[15] || instr[31:26] == OPCODE_BRANCH) && guard < ROM_DEPTH) begin
            step_once();
            instr = rom_word(model_pc);
            guard++;
        end
        if (!instr[15] || instr[31:26] == OPCODE_BRANCH) begin
            $display("ERROR: negative immediate test never reached a negative immediate");
            error_count++;
        end
        capture_snapshot();
        check_selection("negative immediate", CMD_IMMEDIATE);
        end_test("negative_immediate");
    endtask

    task automatic test_run_to_halt();
        logic [DATA_WIDTH-1:0] status;
        int unsigned           cycles;
        start_test();
        apb_write(REG_CTRL, DATA_WIDTH'(1) << CTRL_RUN_BIT);
        cycles = 0;
        status = '0;
        while (!status[STATUS_HALTED_BIT] && cycles < WAIT_LIMIT) begin
            apb_read(REG_STATUS, status);
            cycles++;
        end
        if (!status[STATUS_HALTED_BIT]) begin
            timeout_abort("halted never set while running");
        end else begin
            compare_status("halt status running", 1'b1, 1'b1, status);
            cycles = 0;
            while (!model_halted && cycles < WAIT_LIMIT) begin
                model_advance();
                cycles++;
            end
            apb_write(REG_CTRL, '0);
            apb_read(REG_STATUS, status);
            compare_status("halt status", 1'b1, 1'b0, status);
            capture_snapshot();
            check_selection("halt instruction", CMD_INSTRUCTION);
            check_selection("halt pc_cycles", CMD_PC_CYCLES);
            repeat (3) step_once(); // Nothing moves while halted.
            capture_snapshot();
            check_selection("halt frozen pc_cycles", CMD_PC_CYCLES);
            check_selection("halt frozen decode", CMD_DECODE);
            end_test("run_to_halt");
        end
    endtask

    task automatic test_clear();
        logic [DATA_WIDTH-1:0] status;
        start_test();
        apb_write(REG_CTRL, DATA_WIDTH'(1) << CTRL_CLEAR_BIT);
        model_reset();
        apb_read(REG_STATUS, status);
        compare_status("clear status", 1'b0, 1'b0, status);
        capture_snapshot();
        check_selection("clear pc_cycles", CMD_PC_CYCLES);
        repeat (2) step_once();
        capture_snapshot();
        apb_write(REG_CMD, DATA_WIDTH'(CMD_CLEAR));
        held_zero = 1'b1;
        check_selection("cmd clear pc_cycles", CMD_PC_CYCLES);
        check_selection("cmd clear instruction", CMD_INSTRUCTION);
        end_test("clear");
    endtask

    initial begin
        psel        <= 1'b0;
        penable     <= 1'b0;
        pwrite      <= 1'b0;
        paddr       <= '0;
        pwdata      <= '0;
        rng_state   = 32'd34217;
        error_count = 0;
        test_count  = 0;
        held_pc     = '0;
        held_count  = '0;
        held_halted = 1'b0;
        held_zero   = 1'b1;
        model_reset();
        wait_reset_release();
        test_reset_state();
        test_random_steps();
        test_branch();
        test_negative_immediate();
        test_run_to_halt();
        test_clear();
        finish_run();
    end

endmodule

`default_nettype wire

// ==== sim.f ====
design/debug_pkg.sv
design/pipe_pkg.sv
design/fetch_decode_stage.sv
design/snapshot_database.sv
design/debug_regs.sv
design/debug_top.sv
tests/tb_clock.sv
tests/tb_debug_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the debug subsystem testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f sim.f --top-module tb_debug_top -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_debug_top > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "all tests passed" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
